// ==== Bender.yml ====
package:
  name: mm_tile

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tile_pkg.sv
      - hdl/x_pad_scm.sv
      - hdl/w_buffer.sv
      - hdl/mac_array.sv
      - hdl/apb_tile_ctrl.sv
      - hdl/mm_tile_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_mm_tile.sv

// ==== hdl/apb_tile_ctrl.sv ====
// APB register interface of the tile, with X row staging and the run sequencer.
`timescale 1ns/1ns
`include "tile_params.svh"

module apb_tile_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [`TILE_APB_AW-1:0]          paddr_i,
  input  logic [31:0]                      pwdata_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  output logic                             x_we_o,
  output tile_pkg::row_idx_t               x_waddr_o,
  output tile_pkg::word_t [`TILE_COLS-1:0] x_wdata_o,
  output logic                             w_we_o,
  output tile_pkg::col_idx_t               w_waddr_o,
  output tile_pkg::word_t                  w_wdata_o,
  output logic                             rd_en_o,
  output tile_pkg::col_idx_t               rd_col_o,
  output logic                             acc_clr_o,
  output logic                             acc_en_o,
  input  tile_pkg::acc_t  [`TILE_ROWS-1:0] acc_i
);

  logic                    access;
  logic                    wr_access;
  logic                    aligned;
  logic [`TILE_APB_AW-1:0] x_off;
  logic [`TILE_APB_AW-1:0] w_off;
  logic [`TILE_APB_AW-1:0] y_off;
  logic                    is_ctrl;
  logic                    is_status;
  logic                    is_x;
  logic                    is_w;
  logic                    is_y;
  logic                    mapped;
  logic                    busy;
  logic                    start;
  tile_pkg::row_idx_t      y_row;
  tile_pkg::word_t [1:0]   x_lo_q;
  tile_pkg::ctrl_state_e   state_q;
  logic                    done_q;
  logic                    acc_clr_q;
  logic                    acc_en_q;
  logic                    rd_en_q;
  tile_pkg::col_idx_t      rd_col_q;

  // ==========================================================================
  // address decode
  // ==========================================================================

  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i;
  assign aligned   = (paddr_i[1:0] == 2'b00);

  // offsets below a base wrap to large values and fall out of the range checks.
  assign x_off = paddr_i - `TILE_APB_AW'(`TILE_REG_X_BASE);
  assign w_off = paddr_i - `TILE_APB_AW'(`TILE_REG_W_BASE);
  assign y_off = paddr_i - `TILE_APB_AW'(`TILE_REG_Y_BASE);

  assign is_ctrl   = aligned && (paddr_i == `TILE_APB_AW'(`TILE_REG_CTRL));
  assign is_status = aligned && (paddr_i == `TILE_APB_AW'(`TILE_REG_STATUS));
  assign is_x      = aligned && (x_off < `TILE_ROWS * 8);
  assign is_w      = aligned && (w_off < `TILE_COLS * 4);
  assign is_y      = aligned && (y_off < `TILE_ROWS * 4);
  assign mapped    = is_ctrl | is_status | is_x | is_w | is_y;

  assign busy  = (state_q != tile_pkg::IDLE);
  assign start = wr_access & is_ctrl & pwdata_i[0] & ~busy;
  assign y_row = y_off[3:2];

  // no wait states. Errors cover unmapped accesses and X or W writes during a run.
  assign pready_o  = 1'b1;
  assign pslverr_o = access & (~mapped | (pwrite_i & busy & (is_x | is_w)));

  // ==========================================================================
  // store writes
  // ==========================================================================

  // the low half of a row waits here until the high half commits it.
  always_ff @(posedge clk_i) begin
    if (wr_access && is_x && !x_off[2] && !busy) begin
      x_lo_q[0] <= pwdata_i[15:0];
      x_lo_q[1] <= pwdata_i[31:16];
    end
  end

  assign x_we_o    = wr_access & is_x & x_off[2] & ~busy;
  assign x_waddr_o = x_off[4:3];
  assign x_wdata_o = {pwdata_i[31:16], pwdata_i[15:0], x_lo_q[1], x_lo_q[0]};

  assign w_we_o    = wr_access & is_w & ~busy;
  assign w_waddr_o = w_off[3:2];
  assign w_wdata_o = pwdata_i[15:0];

  // ==========================================================================
  // run sequencer
  // ==========================================================================

  // the clear cycle comes first, then one column read per cycle, and DRAIN holds
  // the last accumulate before done is raised.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= tile_pkg::IDLE;
      done_q    <= 1'b0;
      acc_clr_q <= 1'b0;
      acc_en_q  <= 1'b0;
      rd_en_q   <= 1'b0;
      rd_col_q  <= '0;
    end else begin
      acc_clr_q <= start;
      acc_en_q  <= rd_en_q;
      unique case (state_q)
        tile_pkg::IDLE: begin
          if (start) begin
            state_q <= tile_pkg::RUN;
            done_q  <= 1'b0;
          end
        end
        tile_pkg::RUN: begin
          if (acc_clr_q) begin
            rd_en_q  <= 1'b1;
            rd_col_q <= '0;
          end else if (rd_col_q == tile_pkg::col_idx_t'(`TILE_COLS - 1)) begin
            rd_en_q <= 1'b0;
            state_q <= tile_pkg::DRAIN;
          end else begin
            rd_col_q <= rd_col_q + 1'b1;
          end
        end
        tile_pkg::DRAIN: begin
          state_q <= tile_pkg::IDLE;
          done_q  <= 1'b1;
        end
        default: state_q <= tile_pkg::IDLE;
      endcase
    end
  end

  assign acc_clr_o = acc_clr_q;
  assign acc_en_o  = acc_en_q;
  assign rd_en_o   = rd_en_q;
  assign rd_col_o  = rd_col_q;

  // read data is only driven during a read access phase.
  always_comb begin
    prdata_o = '0;
    if (access && !pwrite_i) begin
      if (is_status) begin
        prdata_o = {30'b0, done_q, busy};
      end else if (is_y) begin
        prdata_o = acc_i[y_row];
      end
    end
  end

endmodule

// ==== hdl/mac_array.sv ====
// Row of multiply-accumulate lanes that folds one X column and one W word into the y sums.
`timescale 1ns/1ns
`include "tile_params.svh"

module mac_array (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clr_i,
  input  logic                             acc_en_i,
  input  tile_pkg::word_t [`TILE_ROWS-1:0] x_col_i,
  input  tile_pkg::word_t                  w_i,
  output tile_pkg::acc_t  [`TILE_ROWS-1:0] acc_o
);

  tile_pkg::acc_t prod [`TILE_ROWS];
  tile_pkg::acc_t acc_q [`TILE_ROWS];

  // ==========================================================================
  // lanes
  // ==========================================================================

  for (genvar r = 0; r < `TILE_ROWS; r++) begin : gen_lanes
    // both factors are unsigned and the full product fits the accumulator width.
    assign prod[r] = tile_pkg::acc_t'(x_col_i[r]) * tile_pkg::acc_t'(w_i);

    // clear wins over accumulate.
    // The sum simply wraps modulo 2^32.
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        acc_q[r] <= '0;
      end else if (clr_i) begin
        acc_q[r] <= '0;
      end else if (acc_en_i) begin
        acc_q[r] <= acc_q[r] + prod[r];
      end
    end

    assign acc_o[r] = acc_q[r];
  end

endmodule

// ==== hdl/mm_tile_top.sv ====
// Top level of the matrix-vector tile, joining the APB controller, both stores and the MACs.
`timescale 1ns/1ns
`include "tile_params.svh"

module mm_tile_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`TILE_APB_AW-1:0] paddr_i,
  input  logic [31:0]             pwdata_i,
  output logic [31:0]             prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  logic                             x_we;
  tile_pkg::row_idx_t               x_waddr;
  tile_pkg::word_t [`TILE_COLS-1:0] x_wdata;
  logic                             w_we;
  tile_pkg::col_idx_t               w_waddr;
  tile_pkg::word_t                  w_wdata;
  logic                             rd_en;
  tile_pkg::col_idx_t               rd_col;
  tile_pkg::word_t [`TILE_ROWS-1:0] x_col;
  tile_pkg::word_t                  w_word;
  logic                             acc_clr;
  logic                             acc_en;
  tile_pkg::acc_t  [`TILE_ROWS-1:0] acc;

  apb_tile_ctrl i_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .x_we_o    (x_we),
    .x_waddr_o (x_waddr),
    .x_wdata_o (x_wdata),
    .w_we_o    (w_we),
    .w_waddr_o (w_waddr),
    .w_wdata_o (w_wdata),
    .rd_en_o   (rd_en),
    .rd_col_o  (rd_col),
    .acc_clr_o (acc_clr),
    .acc_en_o  (acc_en),
    .acc_i     (acc)
  );

  // both stores see the same column read, so their outputs arrive together.
  x_pad_scm #(
    .ROWS (`TILE_ROWS),
    .COLS (`TILE_COLS)
  ) i_x_pad (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .write_en_i   (x_we),
    .write_addr_i (x_waddr),
    .wdata_i      (x_wdata),
    .read_en_i    (rd_en),
    .read_addr_i  (rd_col),
    .rdata_o      (x_col)
  );

  w_buffer i_w_buf (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .write_en_i   (w_we),
    .write_addr_i (w_waddr),
    .wdata_i      (w_wdata),
    .read_en_i    (rd_en),
    .read_addr_i  (rd_col),
    .rdata_o      (w_word)
  );

  mac_array i_mac (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (acc_clr),
    .acc_en_i (acc_en),
    .x_col_i  (x_col),
    .w_i      (w_word),
    .acc_o    (acc)
  );

endmodule

// ==== hdl/tile_params.svh ====
// Tile geometry, word widths and APB register offsets, included by every RTL file of the tile.
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

`define TILE_ROWS   4
`define TILE_COLS   4
`define TILE_WORD_W 16
`define TILE_ACC_W  32
`define TILE_APB_AW 8

`define TILE_REG_CTRL   'h00
`define TILE_REG_STATUS 'h04
`define TILE_REG_X_BASE 'h20
`define TILE_REG_W_BASE 'h40
`define TILE_REG_Y_BASE 'h60

`endif

// ==== hdl/tile_pkg.sv ====
// Shared data types and FSM states of the tile, referenced by scoped name from the RTL.
`include "tile_params.svh"

package tile_pkg;

  // one element of X or W.
  typedef logic [`TILE_WORD_W-1:0] word_t;

  // one accumulator lane, also the width of a y result register.
  typedef logic [`TILE_ACC_W-1:0] acc_t;

  // index of an X row, or of an accumulator lane.
  typedef logic [$clog2(`TILE_ROWS)-1:0] row_idx_t;

  // index of an X column, or of a W word.
  typedef logic [$clog2(`TILE_COLS)-1:0] col_idx_t;

  // run sequencing of the APB controller.
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } ctrl_state_e;

endpackage

// ==== hdl/w_buffer.sv ====
// Flip-flop store for the W vector whose column read lines up with the X scratchpad output.
`timescale 1ns/1ns
`include "tile_params.svh"

module w_buffer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               write_en_i,
  input  tile_pkg::col_idx_t write_addr_i,
  input  tile_pkg::word_t    wdata_i,
  input  logic               read_en_i,
  input  tile_pkg::col_idx_t read_addr_i,
  output tile_pkg::word_t    rdata_o
);

  tile_pkg::word_t [`TILE_COLS-1:0] w_q;
  tile_pkg::col_idx_t               read_addr_q;

  // a write lands at its access edge and is readable in the next cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_q <= '0;
    end else if (write_en_i) begin
      w_q[write_addr_i] <= wdata_i;
    end
  end

  // same one-cycle read latency as the scratchpad.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_addr_q <= '0;
    end else if (read_en_i) begin
      read_addr_q <= read_addr_i;
    end
  end

  assign rdata_o = w_q[read_addr_q];

endmodule

// ==== hdl/x_pad_scm.sv ====
// Latch-based X scratchpad that is written one row at a time and read one column at a time.
`timescale 1ns/1ns

module x_pad_scm #(
  parameter int unsigned ROWS = 4,
  parameter int unsigned COLS = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         write_en_i,
  input  tile_pkg::row_idx_t           write_addr_i,
  input  tile_pkg::word_t [COLS-1:0]   wdata_i,
  input  logic                         read_en_i,
  input  tile_pkg::col_idx_t           read_addr_i,
  output tile_pkg::word_t [ROWS-1:0]   rdata_o
);

  tile_pkg::word_t [COLS-1:0] wdata_q;
  tile_pkg::word_t [COLS-1:0] mem_q [ROWS];
  tile_pkg::col_idx_t         read_addr_q;
  logic [ROWS-1:0]            gate_en_q;
  logic [ROWS-1:0]            clk_row;

  // ==========================================================================
  // write path
  // ==========================================================================

  // the row data is held in flops so it stays stable while a row latch is open.
  always_ff @(posedge clk_i) begin
    if (write_en_i) begin
      wdata_q <= wdata_i;
    end
  end

  for (genvar r = 0; r < ROWS; r++) begin : gen_rows
    // behavioural clock gate, the enable is caught while the clock is low.
    always_latch begin
      if (!clk_i) begin
        gate_en_q[r] <= write_en_i && (write_addr_i == tile_pkg::row_idx_t'(r));
      end
    end

    assign clk_row[r] = clk_i & gate_en_q[r];

    // the row opens in the high phase right after the write edge.
    always_latch begin
      if (clk_row[r]) begin
        mem_q[r] <= wdata_q;
      end
    end
  end

  // ==========================================================================
  // read path
  // ==========================================================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_addr_q <= '0;
    end else if (read_en_i) begin
      read_addr_q <= read_addr_i;
    end
  end

  // every row gives its word at the selected column, so rows come out as a column.
  for (genvar r = 0; r < ROWS; r++) begin : gen_read
    assign rdata_o[r] = mem_q[r][read_addr_q];
  end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/tile_pkg.sv
hdl/x_pad_scm.sv
hdl/w_buffer.sv
hdl/mac_array.sv
hdl/apb_tile_ctrl.sv
hdl/mm_tile_top.sv
test/tb_mm_tile.sv

// ==== test/tb_mm_tile.sv ====
// Self-checking testbench that loads X and W over APB, runs the tile and checks every y result.
`timescale 1ns/1ns
`include "tile_params.svh"

module tb_mm_tile;

  localparam int poll_limit = 50;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    psel_i;
  logic                    penable_i;
  logic                    pwrite_i;
  logic [`TILE_APB_AW-1:0] paddr_i;
  logic [31:0]             pwdata_i;
  logic [31:0]             prdata_o;
  logic                    pready_o;
  logic                    pslverr_o;

  // host-side copy of the tile contents.
  logic [15:0] x_ref [`TILE_ROWS][`TILE_COLS];
  logic [15:0] w_ref [`TILE_COLS];
  int          seed;

  always #2 clk_i = ~clk_i;

  mm_tile_top i_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  // ==========================================================================
  // reference model and checking
  // ==========================================================================

  // y[r] is the sum of X[r][c] * W[c], wrapping at 32 bits.
  function automatic logic [31:0] expected_y(input int r);
    logic [31:0] sum;
    logic [31:0] xv;
    logic [31:0] wv;
    sum = '0;
    for (int c = 0; c < `TILE_COLS; c++) begin
      xv  = {16'h0, x_ref[r][c]};
      wv  = {16'h0, w_ref[c]};
      sum = sum + xv * wv;
    end
    return sum;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: time %0t, %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // ==========================================================================
  // APB host
  // ==========================================================================

  // each access is called 1 ns after a rising edge and takes exactly two cycles.
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    #2;
    check_value("pready_o", {31'b0, pready_o}, 32'd1);
    check_value("pslverr_o", {31'b0, pslverr_o}, {31'b0, exp_err});
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          input logic exp_err);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    #2;
    data = prdata_o;
    check_value("pready_o", {31'b0, pready_o}, 32'd1);
    check_value("pslverr_o", {31'b0, pslverr_o}, {31'b0, exp_err});
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic put_x_row(input int r);
    apb_write(8'(`TILE_REG_X_BASE + 8 * r), {x_ref[r][1], x_ref[r][0]}, 1'b0);
    apb_write(8'(`TILE_REG_X_BASE + 8 * r + 4), {x_ref[r][3], x_ref[r][2]}, 1'b0);
  endtask

  task automatic put_w_word(input int c);
    apb_write(8'(`TILE_REG_W_BASE + 4 * c), {16'h0, w_ref[c]}, 1'b0);
  endtask

  task automatic randomize_tile();
    logic [31:0] rnd;
    for (int r = 0; r < `TILE_ROWS; r++) begin
      for (int c = 0; c < `TILE_COLS; c++) begin
        rnd         = $random(seed);
        x_ref[r][c] = rnd[15:0];
      end
    end
    for (int c = 0; c < `TILE_COLS; c++) begin
      rnd      = $random(seed);
      w_ref[c] = rnd[15:0];
    end
  endtask

  task automatic load_tile();
    for (int r = 0; r < `TILE_ROWS; r++) begin
      put_x_row(r);
    end
    for (int c = 0; c < `TILE_COLS; c++) begin
      put_w_word(c);
    end
  endtask

  // polls STATUS until done, then expects done set and busy clear.
  task automatic poll_done();
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (status[1] == 1'b0) begin
      if (polls == poll_limit) begin
        $display("timeout: done was not set after %0d status reads", poll_limit);
        $display("TEST FAILED");
        $fatal(1, "timeout while polling status");
      end
      apb_read(8'(`TILE_REG_STATUS), status, 1'b0);
      polls++;
    end
    check_value("status", status, 32'h2);
  endtask

  task automatic check_results();
    logic [31:0] data;
    for (int r = 0; r < `TILE_ROWS; r++) begin
      apb_read(8'(`TILE_REG_Y_BASE + 4 * r), data, 1'b0);
      check_value($sformatf("y[%0d]", r), data, expected_y(r));
    end
  endtask

  task automatic run_and_check();
    apb_write(8'(`TILE_REG_CTRL), 32'h1, 1'b0);
    poll_done();
    check_results();
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    logic [31:0] data;
    logic [31:0] rnd;
    seed      = 32'h073afe33;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    // idle status and cleared accumulators after reset.
    apb_read(8'(`TILE_REG_STATUS), data, 1'b0);
    check_value("status", data, 32'h0);
    for (int r = 0; r < `TILE_ROWS; r++) begin
      apb_read(8'(`TILE_REG_Y_BASE + 4 * r), data, 1'b0);
      check_value($sformatf("y[%0d]", r), data, 32'h0);
    end

    randomize_tile();
    load_tile();
    run_and_check();

    // only row 2 and W[1] change, the other rows must survive.
    for (int c = 0; c < `TILE_COLS; c++) begin
      rnd         = $random(seed);
      x_ref[2][c] = rnd[15:0];
    end
    rnd      = $random(seed);
    w_ref[1] = rnd[15:0];
    put_x_row(2);
    put_w_word(1);
    run_and_check();

    // all ones makes every sum overflow 32 bits.
    for (int r = 0; r < `TILE_ROWS; r++) begin
      for (int c = 0; c < `TILE_COLS; c++) begin
        x_ref[r][c] = 16'hffff;
      end
    end
    for (int c = 0; c < `TILE_COLS; c++) begin
      w_ref[c] = 16'hffff;
    end
    load_tile();
    run_and_check();

    // accesses back to back with a start land two, four and six cycles into the run.
    randomize_tile();
    load_tile();
    apb_write(8'(`TILE_REG_CTRL), 32'h1, 1'b0);
    apb_write(8'(`TILE_REG_X_BASE + 12), 32'h1234_5678, 1'b1);
    apb_write(8'(`TILE_REG_CTRL), 32'h1, 1'b0);
    apb_write(8'(`TILE_REG_W_BASE + 8), 32'h0000_beef, 1'b1);
    // a restart would still be busy here.
    apb_read(8'(`TILE_REG_STATUS), data, 1'b0);
    check_value("status", data, 32'h2);
    check_results();
    apb_read(8'h10, data, 1'b1);
    apb_write(8'h80, 32'hffff_ffff, 1'b1);
    // a fresh run shows that none of the rejected writes reached X or W.
    run_and_check();

    $display("TEST PASSED");
    $finish;
  end

endmodule
